// ==== source/imuldiv_defs.svh ====
/* multiply/divide unit constants
   function codes on the request port, operand width and step count */

`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// ----------------------------------------------------------------------
// function codes carried on req_fn
// ----------------------------------------------------------------------

// signed 32x32 -> 64 multiply
`define IMULDIV_FN_MUL   2'd0
// signed divide, remainder in upper half
`define IMULDIV_FN_DIV   2'd1
// unsigned divide
`define IMULDIV_FN_DIVU  2'd2

// ----------------------------------------------------------------------
// sizes
// ----------------------------------------------------------------------

// operand width in bits
`define IMULDIV_XLEN     32
// one shift step per operand bit
`define IMULDIV_STEPS    32

`endif

// ==== source/imuldiv_pkg.sv ====
/* imuldiv_pkg
   shared vector and state types for the multiply/divide unit */

`default_nettype none

`include "imuldiv_defs.svh"

package imuldiv_pkg;

  // single operand word
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // full product, or remainder:quotient pair
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

  // iteration counter, counts down from STEPS-1 to zero
  typedef logic [$clog2(`IMULDIV_STEPS)-1:0] count_t;

  // function code from the request port
  typedef logic [1:0] fn_t;

  // control FSM shared by both iterative units
  // idle waits for a request, calc runs the steps,
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_t;

endpackage

`default_nettype wire

// ==== source/int_mul_dpath.sv ====
/* int_mul_dpath
   shift-and-add multiplier datapath working on operand magnitudes,
   with the product sign applied at the output */

`timescale 1ns/100ps
`default_nettype none

`include "imuldiv_defs.svh"

module int_mul_dpath (
  input  wire                     clk,
  input  wire                     reset,
  input  wire imuldiv_pkg::word_t a_in,
  input  wire imuldiv_pkg::word_t b_in,
  input  wire                     a_en,
  input  wire                     b_en,
  input  wire                     load,
  input  wire                     result_en,
  input  wire                     cntr_en,
  input  wire                     sign_en,
  input  wire                     sign_fix,
  output logic                    counter_is_zero,
  output logic                    b_lsb,
  output logic                    sign,
  output imuldiv_pkg::dword_t     result
);

  import imuldiv_pkg::*;

  word_t  a_mag;
  word_t  b_mag;
  dword_t a_reg;
  word_t  b_reg;
  dword_t acc_reg;
  count_t counter;
  logic   sign_reg;

  // magnitudes of the incoming operands
  // the most negative value maps onto itself, which is right as unsigned
  assign a_mag = a_in[`IMULDIV_XLEN-1] ? (~a_in + 1'b1) : a_in;
  assign b_mag = b_in[`IMULDIV_XLEN-1] ? (~b_in + 1'b1) : b_in;

  // ----------------------------------------------------------------------
  // operand shifters and accumulator
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // multiplicand widens to 64 bits and moves up one place per step
    if (a_en) begin
      a_reg <= load ? {{`IMULDIV_XLEN{1'b0}}, a_mag} : (a_reg << 1);
    end
    // multiplier moves down so its next bit sits at bit 0
    if (b_en) begin
      b_reg <= load ? b_mag : (b_reg >> 1);
    end
    // cleared on load, otherwise picks up the shifted multiplicand
    if (result_en) begin
      acc_reg <= load ? '0 : (acc_reg + a_reg);
    end
  end

  // ----------------------------------------------------------------------
  // step counter and product sign
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      counter  <= '0;
      sign_reg <= 1'b0;
    end else begin
      if (cntr_en) begin
        counter <= load ? count_t'(`IMULDIV_STEPS - 1) : (counter - 1'b1);
      end
      // product is negative when exactly one operand is
      if (sign_en) begin
        sign_reg <= a_in[`IMULDIV_XLEN-1] ^ b_in[`IMULDIV_XLEN-1];
      end
    end
  end

  // status back to the control FSM
  assign counter_is_zero = (counter == '0);
  assign b_lsb           = b_reg[0];
  assign sign            = sign_reg;

  // two's complement of the magnitude product when the sign calls for it
  assign result = sign_fix ? (~acc_reg + 1'b1) : acc_reg;

endmodule

`default_nettype wire

// ==== source/int_mul_iterative.sv ====
/* int_mul_iterative
   iterative signed multiplier, one product bit per cycle,
   valid/ready on both the request and the response side */

`timescale 1ns/100ps
`default_nettype none

module int_mul_iterative (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     req_val,
  output logic                    req_rdy,
  input  wire imuldiv_pkg::word_t req_a,
  input  wire imuldiv_pkg::word_t req_b,
  output logic                    resp_val,
  input  wire                     resp_rdy,
  output imuldiv_pkg::dword_t     resp_result
);

  import imuldiv_pkg::*;

  iter_state_t state;
  iter_state_t state_next;

  logic a_en;
  logic b_en;
  logic load;
  logic result_en;
  logic cntr_en;
  logic sign_en;
  logic sign_fix;
  logic counter_is_zero;
  logic b_lsb;
  logic sign;

  int_mul_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .a_in            (req_a),
    .b_in            (req_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .load            (load),
    .result_en       (result_en),
    .cntr_en         (cntr_en),
    .sign_en         (sign_en),
    .sign_fix        (sign_fix),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign            (sign),
    .result          (resp_result)
  );

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    load       = 1'b0;
    a_en       = 1'b0;
    b_en       = 1'b0;
    result_en  = 1'b0;
    cntr_en    = 1'b0;
    sign_en    = 1'b0;
    sign_fix   = 1'b0;
    case (state)
      IDLE: begin
        // rdy is high here, so valid alone means a transfer
        if (req_val) begin
          load       = 1'b1;
          a_en       = 1'b1;
          b_en       = 1'b1;
          result_en  = 1'b1;
          cntr_en    = 1'b1;
          sign_en    = 1'b1;
          state_next = CALC;
        end
      end
      CALC: begin
        a_en      = 1'b1;
        b_en      = 1'b1;
        cntr_en   = 1'b1;
        // add only for a set multiplier bit
        result_en = b_lsb;
        // counter at zero means this is the 32nd step
        if (counter_is_zero) begin
          state_next = DONE;
        end
      end
      DONE: begin
        sign_fix = sign;
        if (resp_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // handshake outputs follow the state only
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

endmodule

`default_nettype wire

// ==== source/int_div_iterative.sv ====
/* int_div_iterative
   restoring shift-and-subtract divider for signed and unsigned operands,
   response is remainder in the upper half and quotient in the lower */

`timescale 1ns/100ps
`default_nettype none

`include "imuldiv_defs.svh"

module int_div_iterative (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     req_val,
  output logic                    req_rdy,
  input  wire                     req_signed,
  input  wire imuldiv_pkg::word_t req_a,
  input  wire imuldiv_pkg::word_t req_b,
  output logic                    resp_val,
  input  wire                     resp_rdy,
  output imuldiv_pkg::dword_t     resp_result
);

  import imuldiv_pkg::*;

  iter_state_t state;
  iter_state_t state_next;
  count_t      count;

  // remainder in [63:32], dividend bits turning into quotient in [31:0]
  dword_t rq_reg;
  word_t  divisor;
  logic   quot_neg;
  logic   rem_neg;

  word_t       a_mag;
  word_t       b_mag;
  logic        a_neg;
  logic        b_neg;
  logic [33:0] trial;
  logic        fits;
  word_t       quot;
  word_t       rem;
  logic        req_go;
  logic        resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------------------------------------
  // operand conditioning
  // ----------------------------------------------------------------------

  // sign bits only count for DIV, DIVU takes raw operands
  assign a_neg = req_signed && req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed && req_b[`IMULDIV_XLEN-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------------------------------------
  // one restoring step
  // ----------------------------------------------------------------------

  // shifted partial remainder is 33 bits wide, rq_reg[63] is its top bit
  // an extra bit on top catches a negative difference
  assign trial = {1'b0, rq_reg[63:31]} - {2'b00, divisor};
  assign fits  = ~trial[33];

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg   <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      divisor  <= b_mag;
      quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
    end else if (state == CALC) begin
      // keep the difference when the divisor fit, else restore the shift
      if (fits) begin
        rq_reg <= {trial[31:0], rq_reg[30:0], 1'b1};
      end else begin
        rq_reg <= {rq_reg[62:0], 1'b0};
      end
    end
  end

  // ----------------------------------------------------------------------
  // control FSM and step counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        count <= count_t'(`IMULDIV_STEPS - 1);
      end else if (state == CALC) begin
        count <= count - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_go) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // last quotient bit is formed on this edge
        if (count == '0) begin
          state_next = DONE;
        end
      end
      DONE: begin
        if (resp_go) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // ----------------------------------------------------------------------
  // sign correction on the way out
  // ----------------------------------------------------------------------

  // truncating division, so the quotient negates as a whole
  assign quot = quot_neg ? (~rq_reg[31:0] + 1'b1) : rq_reg[31:0];
  assign rem  = rem_neg ? (~rq_reg[63:32] + 1'b1) : rq_reg[63:32];

  assign resp_result = {rem, quot};

endmodule

`default_nettype wire

// ==== source/imuldiv_unit.sv ====
/* imuldiv_unit
   multiply/divide top level, sends each request to the multiplier or the
   divider and returns that unit's response, one operation at a time */

`timescale 1ns/100ps
`default_nettype none

`include "imuldiv_defs.svh"

module imuldiv_unit (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     req_val,
  output logic                    req_rdy,
  input  wire imuldiv_pkg::fn_t   req_fn,
  input  wire imuldiv_pkg::word_t req_a,
  input  wire imuldiv_pkg::word_t req_b,
  output logic                    resp_val,
  input  wire                     resp_rdy,
  output imuldiv_pkg::dword_t     resp_result
);

  import imuldiv_pkg::*;

  logic   busy;
  // high when the divider holds the current operation
  logic   owner_div;

  logic   sel_mul;
  logic   sel_div;
  logic   req_go;
  logic   resp_go;

  logic   mulreq_val;
  logic   mulreq_rdy;
  logic   mulresp_val;
  logic   mulresp_rdy;
  dword_t mulresp_result;

  logic   divreq_val;
  logic   divreq_rdy;
  logic   divreq_signed;
  logic   divresp_val;
  logic   divresp_rdy;
  dword_t divresp_result;

  // ----------------------------------------------------------------------
  // request decode
  // ----------------------------------------------------------------------

  assign sel_mul = (req_fn == `IMULDIV_FN_MUL);
  assign sel_div = (req_fn == `IMULDIV_FN_DIV) || (req_fn == `IMULDIV_FN_DIVU);
  assign divreq_signed = (req_fn == `IMULDIV_FN_DIV);

  // both units sit idle whenever the top is not busy
  assign req_rdy = !busy && mulreq_rdy && divreq_rdy;
  assign req_go  = req_val && req_rdy;

  // the idle unit must not see a request while the other one works
  assign mulreq_val = req_val && !busy && sel_mul;
  assign divreq_val = req_val && !busy && sel_div;

  int_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mulreq_val),
    .req_rdy     (mulreq_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mulresp_val),
    .resp_rdy    (mulresp_rdy),
    .resp_result (mulresp_result)
  );

  int_div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (divreq_val),
    .req_rdy     (divreq_rdy),
    .req_signed  (divreq_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (divresp_val),
    .resp_rdy    (divresp_rdy),
    .resp_result (divresp_result)
  );

  // ----------------------------------------------------------------------
  // busy flag, owner and response steering
  // ----------------------------------------------------------------------

  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_go && (sel_mul || sel_div)) begin
      // unknown codes are taken but start nothing
      busy      <= 1'b1;
      owner_div <= sel_div;
    end else if (resp_go) begin
      busy <= 1'b0;
    end
  end

  assign resp_val    = busy && (owner_div ? divresp_val : mulresp_val);
  assign resp_result = owner_div ? divresp_result : mulresp_result;

  // ready goes back only to the unit that owns the response
  assign mulresp_rdy = resp_rdy && !owner_div;
  assign divresp_rdy = resp_rdy && owner_div;

endmodule

`default_nettype wire

// ==== test/imuldiv_tb.sv ====
/* imuldiv_tb
   self-checking testbench for the multiply/divide unit, runs the vector
   file through the request port and checks every response */

`timescale 1ns/100ps
`default_nettype none

`include "imuldiv_defs.svh"

module imuldiv_tb;

  import imuldiv_pkg::*;

  // response valid rises one edge per step after the request transfer
  localparam int resp_latency = `IMULDIV_STEPS;
  localparam int clk_period   = 40;
  localparam int reset_cycles = 5;
  // bound on waiting for req_rdy
  localparam int accept_limit = 50;

  logic   clk;
  logic   reset;
  logic   req_val;
  logic   req_rdy;
  fn_t    req_fn;
  word_t  req_a;
  word_t  req_b;
  logic   resp_val;
  logic   resp_rdy;
  dword_t resp_result;

  // one entry per vector line
  string  vec_name[$];
  fn_t    vec_fn[$];
  word_t  vec_a[$];
  word_t  vec_b[$];
  int     vec_delay[$];
  dword_t vec_exp[$];

  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int watchdog_cycles;

  imuldiv_unit uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string what, input dword_t expected,
                             input dword_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  function automatic string fn_label(input fn_t fn);
    string label;
    case (fn)
      `IMULDIV_FN_MUL:  label = "mul";
      `IMULDIV_FN_DIV:  label = "div";
      `IMULDIV_FN_DIVU: label = "divu";
      default:          label = "bad";
    endcase
    return label;
  endfunction

  // columns: name, fn, a, b, resp_rdy delay, expected result
  task automatic load_vectors();
    int     fd;
    int     count;
    string  line;
    string  name;
    int     fn;
    word_t  a;
    word_t  b;
    int     delay;
    dword_t expected;
    fd = $fopen("test/imuldiv_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open test/imuldiv_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          count = $sscanf(line, "%s %d %h %h %d %h", name, fn, a, b, delay, expected);
          if (count == 6) begin
            vec_name.push_back(name);
            vec_fn.push_back(fn_t'(fn));
            vec_a.push_back(a);
            vec_b.push_back(b);
            vec_delay.push_back(delay);
            vec_exp.push_back(expected);
          end else begin
            $display("error: malformed vector line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic int max_delay();
    int m;
    m = 0;
    foreach (vec_delay[i]) begin
      if (vec_delay[i] > m) begin
        m = vec_delay[i];
      end
    end
    return m;
  endfunction

  // called on a rising edge
  task automatic drive_request(input int idx);
    req_val <= 1'b1;
    req_fn  <= vec_fn[idx];
    req_a   <= vec_a[idx];
    req_b   <= vec_b[idx];
  endtask

  // ----------------------------------------------------------------------
  // one operation, entered on the edge where its request went valid
  // ----------------------------------------------------------------------

  task automatic run_test(input int idx);
    int     waited;
    int     lat;
    logic   rdy_seen;
    logic   resp_seen;
    logic   val_dropped;
    dword_t held;
    string  name;
    name        = vec_name[idx];
    test_errors = 0;
    // previous response must be gone and the unit free right away
    @(negedge clk);
    waited = 1;
    check_value({name, " resp_val before start"}, 64'd0, dword_t'(resp_val));
    while (!req_rdy && waited < accept_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      $display("test %s: request was never accepted", name);
      errors++;
      test_errors++;
    end else begin
      check_value({name, " accept wait"}, 64'd1, dword_t'(waited));
      @(posedge clk);
      // transfer edge, next request goes valid now and waits while busy
      if (idx + 1 < vec_name.size()) begin
        drive_request(idx + 1);
      end else begin
        req_val <= 1'b0;
        req_a   <= $urandom();
        req_b   <= $urandom();
      end
      resp_rdy <= (vec_delay[idx] == 0);
      lat       = 0;
      rdy_seen  = 1'b0;
      resp_seen = 1'b0;
      while (!resp_seen && lat < resp_latency + 10) begin
        @(posedge clk);
        lat++;
        @(negedge clk);
        rdy_seen  = rdy_seen | req_rdy;
        resp_seen = resp_val;
      end
      if (!resp_seen) begin
        $display("test %s: no response within %0d cycles", name, lat);
        errors++;
        test_errors++;
      end else begin
        check_value({name, " latency"}, dword_t'(resp_latency), dword_t'(lat));
        check_value({name, " result"}, vec_exp[idx], resp_result);
        held        = vec_exp[idx];
        val_dropped = 1'b0;
        // back-pressure, resp_rdy low for the vector's delay
        for (int h = 0; h < vec_delay[idx]; h++) begin
          if (resp_result !== vec_exp[idx]) begin
            held = resp_result;
          end
          val_dropped = val_dropped | !resp_val;
          rdy_seen    = rdy_seen | req_rdy;
          @(posedge clk);
          if (h == vec_delay[idx] - 1) begin
            resp_rdy <= 1'b1;
          end
          @(negedge clk);
        end
        // cycle just before the response transfer
        if (resp_result !== vec_exp[idx]) begin
          held = resp_result;
        end
        val_dropped = val_dropped | !resp_val;
        rdy_seen    = rdy_seen | req_rdy;
        check_value({name, " result held"}, vec_exp[idx], held);
        check_value({name, " resp_val dropped"}, 64'd0, dword_t'(val_dropped));
        check_value({name, " req_rdy while busy"}, 64'd0, dword_t'(rdy_seen));
        @(posedge clk);
        resp_rdy <= 1'b0;
      end
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %-14s %-4s ok", name, fn_label(vec_fn[idx]));
    end else begin
      tests_failed++;
      $display("test %-14s %-4s %0d error(s)", name, fn_label(vec_fn[idx]), test_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(41));
    errors          = 0;
    test_errors     = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    watchdog_cycles = 0;
    reset           = 1'b1;
    req_val         = 1'b0;
    req_fn          = `IMULDIV_FN_MUL;
    // idle payload is noise, nothing may start from it
    req_a           = $urandom();
    req_b           = $urandom();
    resp_rdy        = 1'b0;
    load_vectors();
    if (vec_name.size() > 0) begin
      watchdog_cycles = vec_name.size() * (resp_latency + 1 + max_delay() + 20);
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("after reset req_rdy", 64'd1, dword_t'(req_rdy));
      check_value("after reset resp_val", 64'd0, dword_t'(resp_val));
      @(posedge clk);
      drive_request(0);
      for (int i = 0; i < vec_name.size(); i++) begin
        run_test(i);
      end
      @(negedge clk);
      check_value("end of run resp_val", 64'd0, dword_t'(resp_val));
      check_value("end of run req_rdy", 64'd1, dword_t'(req_rdy));
    end else begin
      $display("error: no test vectors were loaded");
      errors++;
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog, armed once the vector count is known
  initial begin
    wait (watchdog_cycles > 0);
    #(watchdog_cycles * clk_period);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/imuldiv_vectors.txt ====
# name fn(0 mul, 1 div, 2 divu) a(hex) b(hex) resp_rdy_delay(cycles) expected(hex)
# div results are remainder in the upper word, quotient in the lower word
mul_small    0 00000007 00000006 0  000000000000002a
mul_neg_pos  0 fffffffd 00000005 0  fffffffffffffff1
mul_neg_neg  0 fffffff9 fffffff8 2  0000000000000038
mul_wide     0 00010000 00010000 0  0000000100000000
mul_min_m1   0 80000000 ffffffff 0  0000000080000000
mul_min_min  0 80000000 80000000 5  4000000000000000
mul_max_max  0 7fffffff 7fffffff 0  3fffffff00000001
mul_zero     0 00000000 12345678 0  0000000000000000
mul_pos_m1   0 12345678 ffffffff 1  ffffffffedcba988
div_pos_pos  1 00000014 00000003 0  0000000200000006
div_neg_pos  1 ffffffec 00000003 0  fffffffefffffffa
div_pos_neg  1 00000014 fffffffd 3  00000002fffffffa
div_neg_neg  1 ffffffec fffffffd 0  fffffffe00000006
div_exact    1 00000064 0000000a 0  000000000000000a
div_min_m1   1 80000000 ffffffff 0  0000000080000000
divu_top_a   2 ffffffec 00000003 0  000000025555554e
divu_big_b   2 80000000 ffffffff 4  8000000000000000
divu_both    2 ffffffff 80000000 0  7fffffff00000001
divu_even    2 12345678 00000002 0  00000000091a2b3c
b2b_mul_a    0 fffffffe 00000003 0  fffffffffffffffa
b2b_div      1 ffffff9c 00000007 0  fffffffefffffff2
b2b_mul_b    0 00000003 00000003 0  0000000000000009
bp_long_div  1 7fffffff 00000010 12 0000000f07ffffff
bp_long_mul  0 fffffc18 000003e8 9  fffffffffff0bdc0

// ==== flist.f ====
+incdir+source
source/imuldiv_pkg.sv
source/int_mul_dpath.sv
source/int_mul_iterative.sv
source/int_div_iterative.sv
source/imuldiv_unit.sv
test/imuldiv_tb.sv

// ==== Makefile ====
# Verilator build and run of the multiply/divide unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       = imuldiv_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***
PASS_MSG  = *** TEST PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
